// ==== sim.f ====
common/trace_pkg.sv
common/link_pkg.sv
tracer/retire_capture.sv
tracer/trace_fifo.sv
tracer/frame_sender.sv
hdl/trace_top.sv
bench/trace_checker.sv
bench/trace_tb.sv

// ==== Makefile ====
# tool, flags, top module and file list
VERILATOR  := verilator
TOP        := trace_tb
FILELIST   := sim.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --top-module $(TOP) --Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only --timing --top-module $(TOP)
PASS_MSG   := Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST)

# the run fails unless the pass line shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/trace_tb.sv ====
// testbench with clock, reset and random core and link stimulus around the trace top
`timescale 1ns/1ns
`default_nettype none

module trace_tb;

  import trace_pkg::*;
  import link_pkg::*;

  localparam int RANDOM_CYCLES  = 4000;
  localparam int SETTLE_TIMEOUT = 2000;
  localparam int OUTAGE_TIMEOUT = 400;
  localparam int OUTAGE_HOLD    = 300; // outage goes on after the stall
  localparam int DRAIN_TIMEOUT  = 4000;
  localparam int QUIET_CYCLES   = 60;

  logic        clk;
  logic        arst_n;
  retire_m_t   retire_m;
  logic        stall_w;
  logic        flush_w;
  gpr_wr_t     gpr_w;
  logic        gmii_clk_en;
  pcs_status_t pcs_status;
  logic        external_stall;
  byte_t       gmii_txd;
  logic        gmii_tx_en;

  int   errors;
  int   frames;
  int   pending;
  int   tests_passed;
  int   tests_failed;
  logic link_up;
  int   link_left; // cycles left in the current link stretch

  always #2 clk = ~clk;

  trace_top trace_top_inst (
    .clk            (clk),
    .arst_n         (arst_n),
    .retire_m       (retire_m),
    .stall_w        (stall_w),
    .flush_w        (flush_w),
    .gpr_w          (gpr_w),
    .external_stall (external_stall),
    .gmii_clk_en    (gmii_clk_en),
    .pcs_status     (pcs_status),
    .gmii_txd       (gmii_txd),
    .gmii_tx_en     (gmii_tx_en)
  );

  trace_checker trace_checker_inst (
    .clk            (clk),
    .arst_n         (arst_n),
    .retire_m       (retire_m),
    .stall_w        (stall_w),
    .flush_w        (flush_w),
    .gpr_w          (gpr_w),
    .external_stall (external_stall),
    .gmii_clk_en    (gmii_clk_en),
    .pcs_status     (pcs_status),
    .gmii_txd       (gmii_txd),
    .gmii_tx_en     (gmii_tx_en),
    .errors         (errors),
    .frames         (frames),
    .pending        (pending)
  );

  //////////////////////////////////////////////////////////////////////
  // stimulus applied on the falling edge
  //////////////////////////////////////////////////////////////////////
  task automatic drive_cycle(input bit traffic);
    @(negedge clk);
    retire_m.valid  = traffic && ($urandom_range(0, 3) != 0);
    retire_m.trap   = traffic && ($urandom_range(0, 15) == 0);
    retire_m.priv   = priv_t'($urandom_range(0, 3));
    retire_m.pc     = {$urandom, $urandom};
    retire_m.instr  = $urandom;
    stall_w         = external_stall || ($urandom_range(0, 7) == 0); // core honors the stall
    flush_w         = ($urandom_range(0, 15) == 0);
    gpr_w.we        = ($urandom_range(0, 1) == 1);
    gpr_w.addr      = reg_addr_t'($urandom_range(0, 31));
    gpr_w.value     = {$urandom, $urandom};
    gmii_clk_en     = ($urandom_range(0, 3) != 0);
    pcs_status.link_status = link_up;
    pcs_status.link_sync   = link_up;
  endtask

  // link flaps with long down stretches
  task automatic step_link();
    if (link_left == 0) begin
      link_up   = ($urandom_range(0, 3) != 0);
      link_left = link_up ? $urandom_range(20, 200) : $urandom_range(50, 300);
    end else begin
      link_left--;
    end
  endtask

  task automatic finish_test(input string name, input int err_mark, input bit ok);
    if (ok && errors == err_mark) begin
      tests_passed++;
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: FAILED with %0d check errors", name, errors - err_mark);
    end
  endtask

  initial begin
    int          err_mark;
    int          cnt;
    int          quiet;
    bit          ok;
    void'($urandom(94));
    clk         = 1'b0;
    arst_n      = 1'b0;
    retire_m    = '0;
    stall_w     = 1'b0;
    flush_w     = 1'b0;
    gpr_w       = '0;
    gmii_clk_en = 1'b0;
    pcs_status  = '0;
    link_up     = 1'b1;
    link_left   = 0;
    tests_passed = 0;
    tests_failed = 0;

    err_mark = errors;
    repeat (5) @(negedge clk);
    arst_n = 1'b1;
    finish_test("reset values", err_mark, 1'b1);

    err_mark = errors;
    for (cnt = 0; cnt < RANDOM_CYCLES; cnt++) begin
      step_link();
      drive_cycle(1'b1);
    end
    ok = (frames > 0);
    if (!ok) begin
      $display("no frame was sent during random traffic");
    end
    finish_test("random traffic", err_mark, ok);

    // start the outage from a fifo below the stall level
    err_mark = errors;
    link_up  = 1'b1;
    cnt      = 0;
    while (external_stall && cnt < SETTLE_TIMEOUT) begin
      drive_cycle(1'b0);
      cnt++;
    end
    ok = !external_stall;
    if (!ok) begin
      $display("external_stall stayed high for %0d cycles with the link up", SETTLE_TIMEOUT);
    end
    link_up = 1'b0;
    cnt     = 0;
    while (!external_stall && cnt < OUTAGE_TIMEOUT) begin
      drive_cycle(1'b1);
      cnt++;
    end
    if (!external_stall) begin
      ok = 1'b0;
      $display("external_stall did not rise within %0d cycles of link outage", OUTAGE_TIMEOUT);
    end
    repeat (OUTAGE_HOLD) drive_cycle(1'b1);
    link_up = 1'b1;
    finish_test("link outage", err_mark, ok);

    // no new retires while every record leaves as a frame
    err_mark = errors;
    cnt      = 0;
    quiet    = 0;
    while (quiet < QUIET_CYCLES && cnt < DRAIN_TIMEOUT) begin
      drive_cycle(1'b0);
      quiet = (pending == 0 && !gmii_tx_en) ? quiet + 1 : 0;
      cnt++;
    end
    ok = (quiet >= QUIET_CYCLES);
    if (!ok) begin
      $display("%0d records still unsent after %0d drain cycles", pending, DRAIN_TIMEOUT);
    end
    finish_test("drain", err_mark, ok);

    $display("tests passed %0d, failed %0d, frames checked %0d, check errors %0d",
             tests_passed, tests_failed, frames, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/trace_checker.sv ====
// trace checker: writeback reference model, gmii frame decoder and record comparison
`timescale 1ns/1ns
`default_nettype none

module trace_checker (
  input  wire                   clk,
  input  wire                   arst_n,
  input  trace_pkg::retire_m_t  retire_m,
  input  wire                   stall_w,
  input  wire                   flush_w,
  input  trace_pkg::gpr_wr_t    gpr_w,
  input  wire                   external_stall,
  input  wire                   gmii_clk_en,
  input  link_pkg::pcs_status_t pcs_status,
  input  link_pkg::byte_t       gmii_txd,
  input  wire                   gmii_tx_en,
  output int                    errors,
  output int                    frames,
  output int                    pending
);

  import trace_pkg::*;
  import link_pkg::*;

  localparam int HDR_BYTES   = PREAMBLE_BYTES + 3; // preamble, sfd, ethertype
  localparam int FRAME_BYTES = HDR_BYTES + RECORD_BYTES;

  trace_rec_t exp_q [$]; // retired records, oldest first
  trace_rec_t new_rec;
  retire_m_t  m_entry;   // reference copy of the writeback entry
  logic       m_present;
  count_t     m_cnt;     // non-trap retires so far
  rec_bits_t  payload;   // last 30 bytes seen, first byte at the bottom
  logic       in_frame;
  int         nbytes;
  int         gap_cnt;   // enabled idle cycles since the last frame
  logic       link_q;    // link status at the previous enabled edge
  logic       hold_q;    // previous edge had the clock enable low
  byte_t      held_txd;
  logic       held_en;
  int         rst_edges;

  initial begin
    errors    = 0;
    frames    = 0;
    pending   = 0;
    rst_edges = 0;
  end

  function automatic byte_t header_byte(input int idx);
    if (idx < PREAMBLE_BYTES) begin
      return PREAMBLE_BYTE;
    end else if (idx == PREAMBLE_BYTES) begin
      return SFD_BYTE;
    end else if (idx == PREAMBLE_BYTES + 1) begin
      return TRACE_ETHERTYPE[15:8]; // high byte goes first
    end
    return TRACE_ETHERTYPE[7:0];
  endfunction

  task automatic check_value(input string name, input logic [63:0] exp_v,
                             input logic [63:0] act_v);
    if (act_v !== exp_v) begin
      errors++;
      $display("MISMATCH %s expected %0h got %0h at %0t", name, exp_v, act_v, $time);
    end
  endtask

  task automatic note_error(input string what);
    errors++;
    $display("ERROR %s at %0t", what, $time);
  endtask

  task automatic compare_record();
    trace_rec_t exp_r;
    trace_rec_t act_r;
    act_r = trace_rec_t'(payload[$bits(trace_rec_t)-1:0]);
    if (nbytes != FRAME_BYTES) begin
      note_error($sformatf("frame had %0d bytes instead of %0d", nbytes, FRAME_BYTES));
    end
    if (exp_q.size() == 0) begin
      note_error("frame sent with no retired instruction left to match");
    end else begin
      exp_r = exp_q.pop_front();
      check_value("rec.pc", exp_r.pc, act_r.pc);
      check_value("rec.instr", 64'(exp_r.instr), 64'(act_r.instr));
      check_value("rec.gpr.we", 64'(exp_r.gpr.we), 64'(act_r.gpr.we));
      check_value("rec.gpr.addr", 64'(exp_r.gpr.addr), 64'(act_r.gpr.addr));
      check_value("rec.gpr.value", exp_r.gpr.value, act_r.gpr.value);
      check_value("rec.priv", 64'(exp_r.priv), 64'(act_r.priv));
      check_value("rec.trap", 64'(exp_r.trap), 64'(act_r.trap));
      check_value("rec.minstret", exp_r.minstret, act_r.minstret);
      check_value("rec.pad", 64'd0, 64'(payload[RECORD_BITS-1:$bits(trace_rec_t)]));
      frames++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // everything samples the pre-edge values at the rising edge
  //////////////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    if (!arst_n) begin
      if (rst_edges > 0) begin
        check_value("gmii_tx_en", 64'd0, 64'(gmii_tx_en));
        check_value("gmii_txd", 64'd0, 64'(gmii_txd));
        check_value("external_stall", 64'd0, 64'(external_stall));
      end
      rst_edges++;
      exp_q.delete();
      m_entry   = '0;
      m_present = 1'b0;
      m_cnt     = '0;
      in_frame  = 1'b0;
      nbytes    = 0;
      gap_cnt   = PACKET_GAP; // sender starts out idle
      link_q    = 1'b0;
      hold_q    = 1'b0;
    end else begin
      if (hold_q) begin
        check_value("gmii_txd on disabled cycle", 64'(held_txd), 64'(gmii_txd));
        check_value("gmii_tx_en on disabled cycle", 64'(held_en), 64'(gmii_tx_en));
      end

      // frame decoder, one byte per enabled cycle
      if (gmii_clk_en) begin
        if (gmii_tx_en) begin
          if (!in_frame) begin
            if (gap_cnt < PACKET_GAP) begin
              note_error($sformatf("frame started after only %0d idle cycles", gap_cnt));
            end
            if (!link_q) begin
              note_error("frame started while link_status was low");
            end
            in_frame = 1'b1;
            nbytes   = 0;
          end
          if (nbytes < HDR_BYTES) begin
            check_value("gmii_txd", 64'(header_byte(nbytes)), 64'(gmii_txd));
          end
          payload = {gmii_txd, payload[RECORD_BITS-1:8]};
          nbytes++;
        end else if (in_frame) begin
          compare_record();
          in_frame = 1'b0;
          gap_cnt  = 1;
        end else if (gap_cnt < 1000) begin
          gap_cnt++;
        end
        link_q = pcs_status.link_status;
      end

      // writeback stage as the core sees it
      if (m_present && !stall_w && !flush_w) begin
        new_rec.minstret = m_cnt;
        new_rec.gpr      = gpr_w;
        new_rec.trap     = m_entry.trap;
        new_rec.priv     = m_entry.priv;
        new_rec.pc       = m_entry.pc;
        new_rec.instr    = m_entry.instr;
        exp_q.push_back(new_rec);
        if (!m_entry.trap) begin
          m_cnt = m_cnt + 64'd1;
        end
      end
      if (flush_w) begin
        m_present = 1'b0;
      end else if (!stall_w) begin
        m_present = retire_m.valid | retire_m.trap;
        m_entry   = retire_m;
      end

      hold_q   = !gmii_clk_en;
      held_txd = gmii_txd;
      held_en  = gmii_tx_en;
    end
    pending = exp_q.size();
  end

endmodule

`default_nettype wire

// ==== hdl/trace_top.sv ====
// trace top: retire capture, record fifo and gmii frame sender
`timescale 1ns/1ns
`default_nettype none

module trace_top (
  input  wire                   clk,
  input  wire                   arst_n,
  // core side
  input  trace_pkg::retire_m_t  retire_m,
  input  wire                   stall_w,
  input  wire                   flush_w,
  input  trace_pkg::gpr_wr_t    gpr_w,
  output logic                  external_stall,
  // link side
  input  wire                   gmii_clk_en,
  input  link_pkg::pcs_status_t pcs_status,
  output link_pkg::byte_t       gmii_txd,
  output logic                  gmii_tx_en
);

  import trace_pkg::*;

  trace_rec_t rec;
  logic       push;
  trace_rec_t head;
  logic       not_empty;
  logic       pop;

  retire_capture retire_capture_inst (
    .clk      (clk),
    .arst_n   (arst_n),
    .retire_m (retire_m),
    .stall_w  (stall_w),
    .flush_w  (flush_w),
    .gpr_w    (gpr_w),
    .rec      (rec),
    .push     (push)
  );

  trace_fifo trace_fifo_inst (
    .clk            (clk),
    .arst_n         (arst_n),
    .push           (push),
    .rec            (rec),
    .pop            (pop),
    .head           (head),
    .not_empty      (not_empty),
    .external_stall (external_stall)
  );

  frame_sender frame_sender_inst (
    .clk         (clk),
    .arst_n      (arst_n),
    .head        (head),
    .not_empty   (not_empty),
    .gmii_clk_en (gmii_clk_en),
    .pcs_status  (pcs_status),
    .pop         (pop),
    .gmii_txd    (gmii_txd),
    .gmii_tx_en  (gmii_tx_en)
  );

endmodule

`default_nettype wire

// ==== tracer/frame_sender.sv ====
// frame sender: turns each fifo record into one ethernet-style frame on gmii
`timescale 1ns/1ns
`default_nettype none

module frame_sender (
  input  wire                   clk,
  input  wire                   arst_n,
  input  trace_pkg::trace_rec_t head,
  input  wire                   not_empty,
  input  wire                   gmii_clk_en,
  input  link_pkg::pcs_status_t pcs_status,
  output logic                  pop,
  output link_pkg::byte_t       gmii_txd,
  output logic                  gmii_tx_en
);

  import trace_pkg::*;
  import link_pkg::*;

  // state names the kind of byte currently on the wire
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_PREAMBLE,
    ST_HEADER,    // sfd, then the two ethertype bytes
    ST_PAYLOAD,
    ST_GAP
  } state_t;

  state_t                 state;
  logic [FRAME_CNT_W-1:0] byte_cnt; // index of the byte on the wire
  rec_bits_t              shift_q;  // padded record, lsb goes out next

  logic start;

  // new frame only from idle with the link up
  assign start = (state == ST_IDLE) & gmii_clk_en & not_empty & pcs_status.link_status;
  assign pop   = start;

  always_ff @(posedge clk) begin
    if (start) begin
      shift_q <= {{REC_PAD_BITS{1'b0}}, head};
    end else if (gmii_clk_en && (state == ST_PAYLOAD ||
                 (state == ST_HEADER && byte_cnt == FRAME_CNT_W'(2)))) begin
      shift_q <= shift_q >> 8;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // byte sequencer, advances on enabled cycles only
  ////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= ST_IDLE;
      byte_cnt   <= '0;
      gmii_txd   <= '0;
      gmii_tx_en <= 1'b0;
    end else if (gmii_clk_en) begin
      case (state)
        ST_IDLE: begin
          if (start) begin
            gmii_txd   <= PREAMBLE_BYTE;
            gmii_tx_en <= 1'b1;
            byte_cnt   <= '0;
            state      <= ST_PREAMBLE;
          end
        end

        ST_PREAMBLE: begin
          if (byte_cnt == FRAME_CNT_W'(PREAMBLE_BYTES - 1)) begin
            gmii_txd <= SFD_BYTE;
            byte_cnt <= '0;
            state    <= ST_HEADER;
          end else begin
            gmii_txd <= PREAMBLE_BYTE;
            byte_cnt <= byte_cnt + 1'b1;
          end
        end

        ST_HEADER: begin
          case (byte_cnt)
            FRAME_CNT_W'(0): begin
              gmii_txd <= TRACE_ETHERTYPE[15:8];
              byte_cnt <= byte_cnt + 1'b1;
            end
            FRAME_CNT_W'(1): begin
              gmii_txd <= TRACE_ETHERTYPE[7:0];
              byte_cnt <= byte_cnt + 1'b1;
            end
            default: begin
              gmii_txd <= shift_q[7:0]; // first payload byte
              byte_cnt <= '0;
              state    <= ST_PAYLOAD;
            end
          endcase
        end

        ST_PAYLOAD: begin
          if (byte_cnt == FRAME_CNT_W'(RECORD_BYTES - 1)) begin
            gmii_txd   <= '0;
            gmii_tx_en <= 1'b0;
            byte_cnt   <= '0;
            state      <= ST_GAP;
          end else begin
            gmii_txd <= shift_q[7:0];
            byte_cnt <= byte_cnt + 1'b1;
          end
        end

        ST_GAP: begin
          if (byte_cnt == FRAME_CNT_W'(PACKET_GAP - 1)) begin
            byte_cnt <= '0;
            state    <= ST_IDLE;
          end else begin
            byte_cnt <= byte_cnt + 1'b1;
          end
        end

        default: begin
          gmii_txd   <= '0;
          gmii_tx_en <= 1'b0;
          byte_cnt   <= '0;
          state      <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== tracer/trace_fifo.sv ====
// trace fifo: circular record buffer that stalls the core when nearly full
`timescale 1ns/1ns
`default_nettype none

module trace_fifo (
  input  wire                   clk,
  input  wire                   arst_n,
  input  wire                   push,
  input  trace_pkg::trace_rec_t rec,
  input  wire                   pop,
  output trace_pkg::trace_rec_t head,
  output logic                  not_empty,
  output logic                  external_stall
);

  import trace_pkg::*;

  trace_rec_t              mem [TRACE_FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0]   wr_ptr;
  logic [FIFO_PTR_W-1:0]   rd_ptr;
  logic [FIFO_CNT_W-1:0]   count_q;
  logic [FIFO_CNT_W-1:0]   count_d;

  // storage, written on every push
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= rec;
    end
  end

  assign head      = mem[rd_ptr];
  assign not_empty = (count_q != '0);

  assign count_d = count_q + FIFO_CNT_W'(push) - FIFO_CNT_W'(pop);

  ////////////////////////////////////////////////////////////////////
  // pointers, occupancy and stall
  ////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr         <= '0;
      rd_ptr         <= '0;
      count_q        <= '0;
      external_stall <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1; // depth is a power of two, wraps
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count_q        <= count_d;
      // from the next occupancy so the core sees it a cycle sooner
      external_stall <= (count_d >= FIFO_CNT_W'(FIFO_STALL_LEVEL));
    end
  end

endmodule

`default_nettype wire

// ==== tracer/retire_capture.sv ====
// retire capture: writeback-stage copy of the core pipeline that builds trace records
`timescale 1ns/1ns
`default_nettype none

module retire_capture (
  input  wire                   clk,
  input  wire                   arst_n,
  input  trace_pkg::retire_m_t  retire_m,
  input  wire                   stall_w,
  input  wire                   flush_w,
  input  trace_pkg::gpr_wr_t    gpr_w,
  output trace_pkg::trace_rec_t rec,
  output logic                  push
);

  import trace_pkg::*;

  retire_m_t wb_q;       // instruction sitting in writeback
  logic      wb_present; // writeback holds something to retire
  count_t    retire_cnt; // non-trap retires so far

  ////////////////////////////////////////////////////////////////////
  // writeback stage
  ////////////////////////////////////////////////////////////////////

  // presence follows flush and stall like the core's own W register
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb_present <= 1'b0;
    end else if (flush_w) begin
      wb_present <= 1'b0;
    end else if (!stall_w) begin
      wb_present <= retire_m.valid | retire_m.trap; // trapped entries retire too
    end
  end

  always_ff @(posedge clk) begin
    if (!flush_w && !stall_w) begin
      wb_q <= retire_m;
    end
  end

  // leaves writeback this cycle
  assign push = wb_present & ~stall_w & ~flush_w;

  ////////////////////////////////////////////////////////////////////
  // record and retire counter
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      retire_cnt <= '0;
    end else if (push && !wb_q.trap) begin
      retire_cnt <= retire_cnt + 64'd1;
    end
  end

  always_comb begin
    rec.minstret = retire_cnt;   // count before this one
    rec.gpr      = gpr_w;        // write happens in the retiring cycle
    rec.trap     = wb_q.trap;
    rec.priv     = wb_q.priv;
    rec.pc       = wb_q.pc;
    rec.instr    = wb_q.instr;
  end

endmodule

`default_nettype wire

// ==== common/link_pkg.sv ====
// link package: gmii byte, pcs status layout and trace frame constants
`default_nettype none

package link_pkg;

  typedef logic [7:0] byte_t; // gmii data

  // pcs/pma status vector, bit 0 first in hardware
  typedef struct packed {
    logic [1:0] pause;              // 15:14
    logic       remote_fault;       // 13
    logic       duplex;             // 12
    logic [1:0] speed;              // 11:10
    logic [1:0] remote_fault_encdg; // 9:8
    logic       phy_link_status;    // 7
    logic       rxnotintable;       // 6
    logic       rxdisperr;          // 5
    logic       rudi_invalid;       // 4
    logic       rudi_i;             // 3
    logic       rudi_c;             // 2
    logic       link_sync;          // 1
    logic       link_status;        // 0
  } pcs_status_t;

  ////////////////////////////////////////////////////////////////////
  // frame layout
  ////////////////////////////////////////////////////////////////////
  localparam int          PREAMBLE_BYTES  = 7;
  localparam byte_t       PREAMBLE_BYTE   = 8'h55;
  localparam byte_t       SFD_BYTE        = 8'hD5;
  localparam logic [15:0] TRACE_ETHERTYPE = 16'h88B5; // high byte on the wire first
  localparam int          PACKET_GAP      = 12;       // enabled idle cycles
  localparam int          FRAME_CNT_W     = 5;        // byte and gap counter

endpackage

`default_nettype wire

// ==== common/trace_pkg.sv ====
// trace package: core-side types, trace record layout and record FIFO constants
`default_nettype none

package trace_pkg;

  ////////////////////////////////////////////////////////////////////
  // plain widths
  ////////////////////////////////////////////////////////////////////
  typedef logic [63:0] xlen_t;     // register or pc value
  typedef logic [31:0] instr_t;    // raw instruction word
  typedef logic [4:0]  reg_addr_t; // gpr number
  typedef logic [1:0]  priv_t;     // privilege mode
  typedef logic [63:0] count_t;    // retire count

  // memory-stage entry as seen by the tracer, 100 bits
  typedef struct packed {
    logic   valid;
    logic   trap;
    priv_t  priv;
    xlen_t  pc;
    instr_t instr;
  } retire_m_t;

  // gpr write in writeback, 70 bits
  typedef struct packed {
    logic      we;
    reg_addr_t addr;
    xlen_t     value;
  } gpr_wr_t;

  // one retired instruction, 233 bits
  typedef struct packed {
    count_t  minstret;
    gpr_wr_t gpr;
    logic    trap;
    priv_t   priv;
    xlen_t   pc;
    instr_t  instr;
  } trace_rec_t;

  localparam int RECORD_BYTES = 30;
  localparam int RECORD_BITS  = RECORD_BYTES * 8;
  localparam int REC_PAD_BITS = RECORD_BITS - $bits(trace_rec_t); // zero pad on top

  typedef logic [RECORD_BITS-1:0] rec_bits_t; // record as sent, padded

  localparam int TRACE_FIFO_DEPTH = 8;
  localparam int FIFO_STALL_LEVEL = 6;  // two entries of margin for the core
  localparam int FIFO_PTR_W       = $clog2(TRACE_FIFO_DEPTH);
  localparam int FIFO_CNT_W       = $clog2(TRACE_FIFO_DEPTH + 1);

endpackage

`default_nettype wire
